//--- dv/serial_tb.sv
`include "serial_defines.svh"

`timescale 1ns/1ns
`default_nettype none

module serial_tb;

    import serial_pkg::*;

    // table entry kinds
    localparam logic [1:0] K_WRITE = 2'd0;
    localparam logic [1:0] K_READ  = 2'd1;
    localparam logic [1:0] K_FRAME = 2'd2;
    localparam logic [1:0] K_IDLE  = 2'd3;

    // dly is the B/R back-pressure for accesses, the wait limit for frames
    // and the quiet time for idle checks
    typedef struct packed {
        logic [1:0]  kind;
        int          group;
        logic [3:0]  addr;
        logic [31:0] data;
        logic [3:0]  strb;
        logic [31:0] expect_val;
        int          dly;
    } entry_t;

    logic        axi_clk = 1'b0;
    logic        axi_resetn;
    logic [3:0]  awaddr;
    logic        awvalid;
    logic        awready;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic        wvalid;
    logic        wready;
    logic [1:0]  bresp;
    logic        bvalid;
    logic        bready;
    logic [3:0]  araddr;
    logic        arvalid;
    logic        arready;
    logic [31:0] rdata;
    logic [1:0]  rresp;
    logic        rvalid;
    logic        rready;
    logic        tx_out;

    entry_t       test_table[$];
    // frame layout {stop2, stop1, parity, start, data[7:0]}
    logic [11:0]  pending[$];
    logic [11:0]  rx_frames[$];
    logic [31:0]  lcg_state = 32'd47843;
    int           error_count = 0;
    int           cycle_count = 0;
    int           cycle_limit = 2000;
    // frame settings while the table is built
    int           b_div = 4;
    parity_mode_t b_par = PARITY_NONE;
    // last written frame settings for the line decoder
    int           shadow_div = 4;
    parity_mode_t shadow_par = PARITY_NONE;
    logic         shadow_stop2 = 1'b0;

    serial_tx_top u_dut (
        .axi_clk    (axi_clk),
        .axi_resetn (axi_resetn),
        .awaddr     (awaddr),
        .awvalid    (awvalid),
        .awready    (awready),
        .wdata      (wdata),
        .wstrb      (wstrb),
        .wvalid     (wvalid),
        .wready     (wready),
        .bresp      (bresp),
        .bvalid     (bvalid),
        .bready     (bready),
        .araddr     (araddr),
        .arvalid    (arvalid),
        .arready    (arready),
        .rdata      (rdata),
        .rresp      (rresp),
        .rvalid     (rvalid),
        .rready     (rready),
        .tx_out     (tx_out)
    );

    always #20 axi_clk = ~axi_clk;

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    // even parity gives an even count of ones over data and parity bit
    function automatic logic expected_parity(input parity_mode_t mode, input logic [7:0] b);
        if (mode == PARITY_EVEN)
            return ^b;
        if (mode == PARITY_ODD)
            return ~^b;
        return 1'b0;
    endfunction

    function automatic string kind_name(input logic [1:0] kind);
        case (kind)
            K_WRITE: return "write";
            K_READ:  return "read";
            K_FRAME: return "frame";
            default: return "idle";
        endcase
    endfunction

    task automatic add_entry(input logic [1:0] kind, input int group, input logic [1:0] reg_idx,
                             input logic [31:0] data, input logic [3:0] strb,
                             input logic [31:0] expect_val, input int dly);
        entry_t e;
        e.kind       = kind;
        e.group      = group;
        e.addr       = {reg_idx, 2'b00};
        e.data       = data;
        e.strb       = strb;
        e.expect_val = expect_val;
        e.dly        = dly;
        test_table.push_back(e);
        if (kind == K_WRITE || kind == K_READ)
            cycle_limit += 200;
        else if (kind == K_IDLE)
            cycle_limit += dly;
    endtask

    task automatic add_write(input int group, input logic [1:0] reg_idx, input logic [31:0] data,
                             input logic [3:0] strb, input int dly);
        add_entry(K_WRITE, group, reg_idx, data, strb, 32'd0, dly);
        if (strb == 4'hf && reg_idx == `SERIAL_REG_CONTROL)
            b_par = parity_mode_t'(data[`SERIAL_CTRL_PARITY_LO +: 2]);
        if (strb == 4'hf && reg_idx == `SERIAL_REG_DIVISOR)
            b_div = {16'd0, data[`SERIAL_DIV_W-1:0]};
    endtask

    // one lcg byte into the data register
    // kept as an expected frame unless it is dropped
    task automatic add_byte(input int group, input logic keep);
        logic [31:0] word;
        lcg_state = lcg_next(lcg_state);
        word = {lcg_state[15:0], lcg_state[31:16]};
        add_write(group, `SERIAL_REG_DATA, word, 4'b0001, 0);
        if (keep)
            pending.push_back({2'b11, expected_parity(b_par, word[7:0]), 1'b0, word[7:0]});
    endtask

    task automatic flush_expects(input int group);
        while (pending.size() > 0)
        begin
            add_entry(K_FRAME, group, 2'd0, 32'd0, 4'd0, {20'd0, pending.pop_front()},
                      36 * b_div + 100);
            cycle_limit += 12 * b_div;
        end
    endtask

    task automatic build_table();
        // after reset
        add_entry(K_READ, 1, `SERIAL_REG_STATUS, 32'd0, 4'd0, 32'h2, 0);
        add_entry(K_READ, 1, `SERIAL_REG_CONTROL, 32'd0, 4'd0, 32'h0, 0);
        add_entry(K_READ, 1, `SERIAL_REG_DIVISOR, 32'd0, 4'd0, 32'h0, 1);
        add_entry(K_IDLE, 1, 2'd0, 32'd0, 4'd0, 32'd0, 20);
        // strobed register writes with back-pressure
        add_write(2, `SERIAL_REG_CONTROL, 32'hA1B2C3D4, 4'b1010, 3);
        add_entry(K_READ, 2, `SERIAL_REG_CONTROL, 32'd0, 4'd0, 32'hA100C300, 2);
        add_write(2, `SERIAL_REG_DIVISOR, 32'h89ABCDEF, 4'b0110, 0);
        add_entry(K_READ, 2, `SERIAL_REG_DIVISOR, 32'd0, 4'd0, 32'h00ABCD00, 4);
        add_write(2, `SERIAL_REG_CONTROL, 32'h0, 4'hf, 1);
        add_entry(K_READ, 2, `SERIAL_REG_DATA, 32'd0, 4'd0, 32'h0, 0);
        // plain frames at divisor 4
        add_write(3, `SERIAL_REG_DIVISOR, 32'd4, 4'hf, 0);
        add_write(3, `SERIAL_REG_CONTROL, 32'h10, 4'hf, 0);
        repeat (8)
            add_byte(3, 1'b1);
        flush_expects(3);
        // even, odd and odd with two stop bits at divisor 5
        add_write(4, `SERIAL_REG_DIVISOR, 32'd5, 4'hf, 0);
        add_write(4, `SERIAL_REG_CONTROL, 32'h14, 4'hf, 0);
        repeat (3)
            add_byte(4, 1'b1);
        flush_expects(4);
        add_write(4, `SERIAL_REG_CONTROL, 32'h18, 4'hf, 0);
        repeat (3)
            add_byte(4, 1'b1);
        flush_expects(4);
        add_write(4, `SERIAL_REG_CONTROL, 32'h8018, 4'hf, 0);
        repeat (3)
            add_byte(4, 1'b1);
        flush_expects(4);
        // overflow where the 17th byte is dropped
        add_write(5, `SERIAL_REG_CONTROL, 32'h0, 4'hf, 0);
        add_write(5, `SERIAL_REG_DIVISOR, 32'd4, 4'hf, 0);
        repeat (16)
            add_byte(5, 1'b1);
        add_byte(5, 1'b0);
        add_entry(K_READ, 5, `SERIAL_REG_STATUS, 32'd0, 4'd0, 32'h5, 0);
        add_write(5, `SERIAL_REG_STATUS, 32'h4, 4'b0001, 0);
        add_entry(K_READ, 5, `SERIAL_REG_STATUS, 32'd0, 4'd0, 32'h1, 0);
        add_write(5, `SERIAL_REG_CONTROL, 32'h10, 4'hf, 0);
        flush_expects(5);
        add_entry(K_READ, 5, `SERIAL_REG_STATUS, 32'd0, 4'd0, 32'h2, 0);
        add_entry(K_IDLE, 5, 2'd0, 32'd0, 4'd0, 32'd0, 60);
    endtask

    // full-word writes set the line decoder's frame settings
    task automatic track_settings(input logic [3:0] addr, input logic [31:0] data,
                                  input logic [3:0] strb);
        if (strb == 4'hf && addr[3:2] == `SERIAL_REG_CONTROL)
        begin
            shadow_par   = parity_mode_t'(data[`SERIAL_CTRL_PARITY_LO +: 2]);
            shadow_stop2 = data[`SERIAL_CTRL_STOP2];
        end
        if (strb == 4'hf && addr[3:2] == `SERIAL_REG_DIVISOR)
            shadow_div = {16'd0, data[`SERIAL_DIV_W-1:0]};
    endtask

    task automatic axi_write(input logic [3:0] addr, input logic [31:0] data,
                             input logic [3:0] strb, input int resp_delay);
        awaddr  = addr;
        wdata   = data;
        wstrb   = strb;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        // awready and wready pulse together before the handshake edge
        while (!awready)
            @(negedge axi_clk);
        if (wready !== 1'b1)
        begin
            $display("[ERROR] wready: expected 0x1 got 0x%h", wready);
            error_count++;
        end
        @(negedge axi_clk);
        awvalid = 1'b0;
        wvalid  = 1'b0;
        // ready lasts for the handshake cycle only
        if (awready !== 1'b0)
        begin
            $display("[ERROR] awready: expected 0x0 got 0x%h", awready);
            error_count++;
        end
        if (wready !== 1'b0)
        begin
            $display("[ERROR] wready: expected 0x0 got 0x%h", wready);
            error_count++;
        end
        // bvalid rises at the handshake edge and holds while bready is low
        for (int i = 0; i <= resp_delay; i++)
        begin
            if (i > 0)
                @(negedge axi_clk);
            if (bvalid !== 1'b1)
            begin
                $display("[ERROR] bvalid: expected 0x1 got 0x%h", bvalid);
                error_count++;
            end
        end
        if (bresp !== 2'b00)
        begin
            $display("[ERROR] bresp: expected 0x0 got 0x%h", bresp);
            error_count++;
        end
        bready = 1'b1;
        @(negedge axi_clk);
        bready = 1'b0;
        if (bvalid !== 1'b0)
        begin
            $display("[ERROR] bvalid after bready: expected 0x0 got 0x%h", bvalid);
            error_count++;
        end
    endtask

    task automatic axi_read(input logic [3:0] addr, input int resp_delay,
                            output logic [31:0] value);
        araddr  = addr;
        arvalid = 1'b1;
        while (!arready)
            @(negedge axi_clk);
        @(negedge axi_clk);
        arvalid = 1'b0;
        if (arready !== 1'b0)
        begin
            $display("[ERROR] arready: expected 0x0 got 0x%h", arready);
            error_count++;
        end
        for (int i = 0; i <= resp_delay; i++)
        begin
            if (i > 0)
                @(negedge axi_clk);
            if (rvalid !== 1'b1)
            begin
                $display("[ERROR] rvalid: expected 0x1 got 0x%h", rvalid);
                error_count++;
            end
        end
        value = rdata;
        if (rresp !== 2'b00)
        begin
            $display("[ERROR] rresp: expected 0x0 got 0x%h", rresp);
            error_count++;
        end
        rready = 1'b1;
        @(negedge axi_clk);
        rready = 1'b0;
        if (rvalid !== 1'b0)
        begin
            $display("[ERROR] rvalid after rready: expected 0x0 got 0x%h", rvalid);
            error_count++;
        end
    endtask

    task automatic check_frame(input logic [11:0] expected, input int wait_limit);
        int          waited;
        logic [11:0] got;
        waited = 0;
        while (rx_frames.size() == 0 && waited < wait_limit)
        begin
            @(negedge axi_clk);
            waited++;
        end
        if (rx_frames.size() == 0)
        begin
            $display("no serial frame arrived within %0d cycles", wait_limit);
            error_count++;
        end
        else
        begin
            got = rx_frames.pop_front();
            if (got !== expected)
            begin
                $display("[ERROR] tx_out frame: expected 0x%h got 0x%h", expected, got);
                error_count++;
            end
        end
    endtask

    task automatic check_idle(input int quiet_cycles);
        repeat (quiet_cycles)
            @(negedge axi_clk);
        if (tx_out !== 1'b1)
        begin
            $display("[ERROR] tx_out: expected 0x1 got 0x%h", tx_out);
            error_count++;
        end
        if (rx_frames.size() != 0)
        begin
            $display("%0d unexpected serial frame(s) seen on the line", rx_frames.size());
            error_count++;
        end
    endtask

    // line decoder samples each bit near the middle of its window
    initial
    begin : line_decoder
        int           div;
        parity_mode_t mode;
        logic         two_stop;
        logic [7:0]   data_bits;
        logic         start_bit;
        logic         par_bit;
        logic [1:0]   stop_bits;
        forever
        begin
            @(negedge axi_clk);
            if (axi_resetn === 1'b1 && tx_out === 1'b0)
            begin
                div      = shadow_div;
                mode     = shadow_par;
                two_stop = shadow_stop2;
                repeat (div / 2)
                    @(negedge axi_clk);
                start_bit = tx_out;
                // lsb first so bits shift in from the top
                repeat (8)
                begin
                    repeat (div)
                        @(negedge axi_clk);
                    data_bits = {tx_out, data_bits[7:1]};
                end
                par_bit = 1'b0;
                if (mode == PARITY_EVEN || mode == PARITY_ODD)
                begin
                    repeat (div)
                        @(negedge axi_clk);
                    par_bit = tx_out;
                end
                repeat (div)
                    @(negedge axi_clk);
                stop_bits = {1'b1, tx_out};
                if (two_stop)
                begin
                    repeat (div)
                        @(negedge axi_clk);
                    stop_bits[1] = tx_out;
                end
                rx_frames.push_back({stop_bits, par_bit, start_bit, data_bits});
            end
        end
    end

    // run limit from the table length
    always @(posedge axi_clk)
    begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= cycle_limit)
        begin
            $display("timeout, the run did not finish within %0d cycles", cycle_limit);
            $display("*** FAILED ***");
            $finish;
        end
    end

    initial
    begin
        entry_t      e;
        int          errs_before;
        logic [31:0] rd_val;
        axi_resetn = 1'b0;
        awaddr     = '0;
        awvalid    = 1'b0;
        wdata      = '0;
        wstrb      = '0;
        wvalid     = 1'b0;
        bready     = 1'b0;
        araddr     = '0;
        arvalid    = 1'b0;
        rready     = 1'b0;
        build_table();
        repeat (4)
            @(negedge axi_clk);
        axi_resetn = 1'b1;
        @(negedge axi_clk);
        for (int idx = 0; idx < test_table.size(); idx++)
        begin
            e = test_table[idx];
            errs_before = error_count;
            case (e.kind)
                K_WRITE:
                begin
                    track_settings(e.addr, e.data, e.strb);
                    axi_write(e.addr, e.data, e.strb, e.dly);
                end
                K_READ:
                begin
                    axi_read(e.addr, e.dly, rd_val);
                    if (rd_val !== e.expect_val)
                    begin
                        $display("[ERROR] rdata at 0x%h: expected 0x%h got 0x%h",
                                 e.addr, e.expect_val, rd_val);
                        error_count++;
                    end
                end
                K_FRAME:
                    check_frame(e.expect_val[11:0], e.dly);
                default:
                    check_idle(e.dly);
            endcase
            $display("test %0d behavior %0d %s: %s", idx, e.group, kind_name(e.kind),
                     (error_count == errs_before) ? "ok" : "failed");
        end
        $display("%0d tests run, %0d errors", test_table.size(), error_count);
        if (error_count == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

//--- filelist.f
+incdir+hdl
hdl/serial_pkg.sv
hdl/serial_axi_regs.sv
hdl/serial_tx_fifo.sv
hdl/serial_transmitter.sv
hdl/serial_tx_top.sv
dv/serial_tb.sv

//--- hdl/serial_axi_regs.sv
`include "serial_defines.svh"

`timescale 1ns/1ns
`default_nettype none

module serial_axi_regs (
    input  wire                            axi_clk,
    input  wire                            axi_resetn,
    input  wire [`SERIAL_ADDR_W-1:0]       awaddr,
    input  wire                            awvalid,
    output logic                           awready,
    input  wire [31:0]                     wdata,
    input  wire [3:0]                      wstrb,
    input  wire                            wvalid,
    output logic                           wready,
    output logic [1:0]                     bresp,
    output logic                           bvalid,
    input  wire                            bready,
    input  wire [`SERIAL_ADDR_W-1:0]       araddr,
    input  wire                            arvalid,
    output logic                           arready,
    output logic [31:0]                    rdata,
    output logic [1:0]                     rresp,
    output logic                           rvalid,
    input  wire                            rready,
    output logic                           push,
    output logic [`SERIAL_DATA_W-1:0]      push_data,
    output logic                           clear_ovf,
    output logic                           tx_enable,
    output serial_pkg::parity_mode_t       parity_mode,
    output logic                           stop2,
    output logic [`SERIAL_DIV_W-1:0]       divisor,
    input  wire                            full,
    input  wire                            empty,
    input  wire                            overflow
);

    import serial_pkg::*;

    localparam logic [1:0] RESP_OKAY = 2'b00;

    // single ready flop drives both aw and w channels
    logic        wr_ready_q;
    logic        wr_fire;
    logic        rd_fire;
    reg_sel_t    wr_sel;
    reg_sel_t    rd_sel;
    logic [31:0] control_q;
    logic [31:0] divisor_q;
    logic [31:0] status_word;

    // merge only the strobed bytes of a write into the old register value
    function automatic logic [31:0] apply_strobe(input logic [31:0] old_val,
                                                 input logic [31:0] new_val,
                                                 input logic [3:0]  strb);
        logic [31:0] result;
        result = old_val;
        for (int i = 0; i < 4; i++)
        begin
            if (strb[i])
                result[i*8 +: 8] = new_val[i*8 +: 8];
        end
        return result;
    endfunction

    assign awready = wr_ready_q;
    assign wready  = wr_ready_q;
    assign bresp   = RESP_OKAY;
    assign rresp   = RESP_OKAY;

    // handshake cycle, master holds address and data while valid
    assign wr_fire = wr_ready_q && awvalid && wvalid;
    assign rd_fire = arready && arvalid;
    assign wr_sel  = reg_sel_t'(awaddr[3:2]);
    assign rd_sel  = reg_sel_t'(araddr[3:2]);

    // write ready pulses once per transaction, never while B is pending
    always_ff @(posedge axi_clk)
    begin
        if (!axi_resetn)
        begin
            wr_ready_q <= 1'b0;
            bvalid     <= 1'b0;
        end
        else
        begin
            wr_ready_q <= awvalid && wvalid && !wr_ready_q && !bvalid;
            if (wr_fire)
                bvalid <= 1'b1;
            else if (bready)
                bvalid <= 1'b0;
        end
    end

    // control and divisor are plain read/write with byte strobes
    always_ff @(posedge axi_clk)
    begin
        if (!axi_resetn)
        begin
            control_q <= '0;
            divisor_q <= '0;
        end
        else if (wr_fire)
        begin
            if (wr_sel == REG_CONTROL)
                control_q <= apply_strobe(control_q, wdata, wstrb);
            if (wr_sel == REG_DIVISOR)
                divisor_q <= apply_strobe(divisor_q, wdata, wstrb);
        end
    end

    // data writes go straight into the fifo on the handshake edge
    assign push      = wr_fire && (wr_sel == REG_DATA) && wstrb[0];
    assign push_data = wdata[`SERIAL_DATA_W-1:0];
    // w1c on the overflow bit, lives in byte 0
    assign clear_ovf = wr_fire && (wr_sel == REG_STATUS) && wstrb[0]
                       && wdata[`SERIAL_STATUS_OVF];

    // frame settings for the transmitter
    assign tx_enable   = control_q[`SERIAL_CTRL_ENABLE];
    assign parity_mode = parity_mode_t'(control_q[`SERIAL_CTRL_PARITY_LO +: 2]);
    assign stop2       = control_q[`SERIAL_CTRL_STOP2];
    assign divisor     = divisor_q[`SERIAL_DIV_W-1:0];

    always_comb
    begin
        status_word = '0;
        status_word[`SERIAL_STATUS_FULL]  = full;
        status_word[`SERIAL_STATUS_EMPTY] = empty;
        status_word[`SERIAL_STATUS_OVF]   = overflow;
    end

    // read address accepted one cycle after arvalid, data one cycle later
    always_ff @(posedge axi_clk)
    begin
        if (!axi_resetn)
        begin
            arready <= 1'b0;
            rvalid  <= 1'b0;
        end
        else
        begin
            arready <= arvalid && !arready && !rvalid;
            if (rd_fire)
                rvalid <= 1'b1;
            else if (rready)
                rvalid <= 1'b0;
        end
    end

    // read mux, the data register has no read path
    always_ff @(posedge axi_clk)
    begin
        if (rd_fire)
        begin
            case (rd_sel)
                REG_STATUS:  rdata <= status_word;
                REG_CONTROL: rdata <= control_q;
                REG_DIVISOR: rdata <= divisor_q;
                default:     rdata <= '0;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hdl/serial_defines.svh
`ifndef SERIAL_DEFINES_SVH
`define SERIAL_DEFINES_SVH

// transmit fifo geometry
`define SERIAL_FIFO_DEPTH 16
`define SERIAL_FIFO_AW 4

// character width, eight data bits only
`define SERIAL_DATA_W 8

// axi4-lite byte address width
`define SERIAL_ADDR_W 4

// register word indices, taken from address bits 3:2
// byte offsets are 0, 4, 8 and 12
`define SERIAL_REG_DATA 2'd0
`define SERIAL_REG_STATUS 2'd1
`define SERIAL_REG_CONTROL 2'd2
`define SERIAL_REG_DIVISOR 2'd3

// status bits, overflow is write-one-to-clear
`define SERIAL_STATUS_FULL 0
`define SERIAL_STATUS_EMPTY 1
`define SERIAL_STATUS_OVF 2

// control bits, parity field is two bits starting at PARITY_LO
`define SERIAL_CTRL_PARITY_LO 2
`define SERIAL_CTRL_ENABLE 4
`define SERIAL_CTRL_STOP2 15

// bit period divisor width, lives in divisor bits 15:0
`define SERIAL_DIV_W 16

`endif

//--- hdl/serial_pkg.sv
`default_nettype none

`include "serial_defines.svh"

package serial_pkg;

    // parity field of the control register
    // value 3 is reserved and sends no parity bit
    typedef enum logic [1:0] {
        PARITY_NONE = 2'd0,
        PARITY_EVEN = 2'd1,
        PARITY_ODD  = 2'd2,
        PARITY_RSVD = 2'd3
    } parity_mode_t;

    // transmitter frame states
    typedef enum logic [2:0] {
        TX_IDLE   = 3'd0,
        TX_START  = 3'd1,
        TX_DATA   = 3'd2,
        TX_PARITY = 3'd3,
        TX_STOP   = 3'd4
    } tx_state_t;

    // register select, decoded from address bits 3:2
    typedef enum logic [1:0] {
        REG_DATA    = `SERIAL_REG_DATA,
        REG_STATUS  = `SERIAL_REG_STATUS,
        REG_CONTROL = `SERIAL_REG_CONTROL,
        REG_DIVISOR = `SERIAL_REG_DIVISOR
    } reg_sel_t;

endpackage

`default_nettype wire

//--- hdl/serial_transmitter.sv
`include "serial_defines.svh"

`timescale 1ns/1ns
`default_nettype none

module serial_transmitter (
    input  wire                        axi_clk,
    input  wire                        axi_resetn,
    input  wire                        tx_enable,
    input  wire serial_pkg::parity_mode_t parity_mode,
    input  wire                        stop2,
    input  wire [`SERIAL_DIV_W-1:0]    divisor,
    input  wire                        empty,
    input  wire [`SERIAL_DATA_W-1:0]   head_data,
    output logic                       pop,
    output logic                       tx_out
);

    import serial_pkg::*;

    tx_state_t                 state;
    logic [`SERIAL_DIV_W-1:0]  baud_cnt;
    logic [2:0]                bit_cnt;
    // frame settings captured at the start bit
    logic [`SERIAL_DATA_W-1:0] shift_q;
    parity_mode_t              par_mode_q;
    logic                      stop2_q;
    logic [`SERIAL_DIV_W-1:0]  div_q;
    logic                      par_acc;
    logic                      parity_on;
    logic                      bit_done;
    logic                      emit_bit;
    logic                      frame_end;
    logic                      start_frame;

    assign parity_on = (par_mode_q == PARITY_EVEN) || (par_mode_q == PARITY_ODD);

    // last cycle of the current bit period
    assign bit_done = (state != TX_IDLE) && (baud_cnt == div_q - 1'b1);

    // next data bit goes onto the line after start and after data bits 0..6
    assign emit_bit = bit_done && ((state == TX_START) ||
                                   ((state == TX_DATA) && (bit_cnt != 3'd7)));

    // final stop bit ends here
    // bit_cnt[0] marks the second stop bit
    assign frame_end = (state == TX_STOP) && bit_done && (!stop2_q || bit_cnt[0]);

    // start from idle or straight after the last stop bit so frames run back to back
    assign start_frame = ((state == TX_IDLE) || frame_end) && tx_enable && !empty;
    assign pop = start_frame;

    always_ff @(posedge axi_clk)
    begin
        if (!axi_resetn)
        begin
            state    <= TX_IDLE;
            baud_cnt <= '0;
            bit_cnt  <= '0;
            tx_out   <= 1'b1;
        end
        else
        begin
            if (bit_done || start_frame)
                baud_cnt <= '0;
            else if (state != TX_IDLE)
                baud_cnt <= baud_cnt + 1'b1;

            if (start_frame)
            begin
                // start bit
                state  <= TX_START;
                tx_out <= 1'b0;
            end
            else if (emit_bit)
            begin
                state   <= TX_DATA;
                tx_out  <= shift_q[0];
                bit_cnt <= (state == TX_START) ? 3'd0 : bit_cnt + 1'b1;
            end
            else if (bit_done)
            begin
                case (state)
                    TX_DATA:
                    begin
                        state   <= parity_on ? TX_PARITY : TX_STOP;
                        tx_out  <= parity_on ? par_acc : 1'b1;
                        bit_cnt <= '0;
                    end
                    TX_PARITY:
                    begin
                        state  <= TX_STOP;
                        tx_out <= 1'b1;
                    end
                    TX_STOP:
                    begin
                        // line is already high for the second stop bit or idle
                        if (frame_end)
                            state <= TX_IDLE;
                        else
                            bit_cnt <= 3'd1;
                    end
                    default:
                        state <= TX_IDLE;
                endcase
            end
        end
    end

    // frame datapath loaded at the start bit and stepped per data bit
    always_ff @(posedge axi_clk)
    begin
        if (start_frame)
        begin
            shift_q    <= head_data;
            par_mode_q <= parity_mode;
            stop2_q    <= stop2;
            div_q      <= divisor;
            // odd parity seeds the accumulator with a one
            par_acc    <= (parity_mode == PARITY_ODD);
        end
        else if (emit_bit)
        begin
            // lsb first and each bit folds into parity as it goes out
            shift_q <= shift_q >> 1;
            par_acc <= par_acc ^ shift_q[0];
        end
    end

endmodule

`default_nettype wire

//--- hdl/serial_tx_fifo.sv
`include "serial_defines.svh"

`timescale 1ns/1ns
`default_nettype none

module serial_tx_fifo (
    input  wire                        axi_clk,
    input  wire                        axi_resetn,
    input  wire                        push,
    input  wire [`SERIAL_DATA_W-1:0]   push_data,
    input  wire                        pop,
    input  wire                        clear_ovf,
    output logic [`SERIAL_DATA_W-1:0]  head_data,
    output logic                       full,
    output logic                       empty,
    output logic                       overflow
);

    logic [`SERIAL_DATA_W-1:0] mem [0:`SERIAL_FIFO_DEPTH-1];
    logic [`SERIAL_FIFO_AW-1:0] wr_ptr;
    logic [`SERIAL_FIFO_AW-1:0] rd_ptr;
    // one extra bit so a full queue is distinct from an empty one
    logic [`SERIAL_FIFO_AW:0]   count;
    logic                       do_push;
    logic                       do_pop;

    assign full  = (count == `SERIAL_FIFO_DEPTH);
    assign empty = (count == 0);

    // a push into a full queue is dropped even if a pop happens too
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    // show-ahead head, valid whenever not empty
    assign head_data = mem[rd_ptr];

    always_ff @(posedge axi_clk)
    begin
        if (do_push)
            mem[wr_ptr] <= push_data;
    end

    always_ff @(posedge axi_clk)
    begin
        if (!axi_resetn)
        begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end
        else
        begin
            // pointers wrap naturally at the power-of-two depth
            if (do_push)
                wr_ptr <= wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= rd_ptr + 1'b1;
            if (do_push && !do_pop)
                count <= count + 1'b1;
            else if (do_pop && !do_push)
                count <= count - 1'b1;
            // sticky, a new overflow wins over a clear in the same cycle
            if (push && full)
                overflow <= 1'b1;
            else if (clear_ovf)
                overflow <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- hdl/serial_tx_top.sv
`include "serial_defines.svh"

`timescale 1ns/1ns
`default_nettype none

module serial_tx_top (
    input  wire                        axi_clk,
    input  wire                        axi_resetn,
    input  wire [`SERIAL_ADDR_W-1:0]   awaddr,
    input  wire                        awvalid,
    output logic                       awready,
    input  wire [31:0]                 wdata,
    input  wire [3:0]                  wstrb,
    input  wire                        wvalid,
    output logic                       wready,
    output logic [1:0]                 bresp,
    output logic                       bvalid,
    input  wire                        bready,
    input  wire [`SERIAL_ADDR_W-1:0]   araddr,
    input  wire                        arvalid,
    output logic                       arready,
    output logic [31:0]                rdata,
    output logic [1:0]                 rresp,
    output logic                       rvalid,
    input  wire                        rready,
    output logic                       tx_out
);

    import serial_pkg::*;

    // register block to fifo
    logic                      push;
    logic [`SERIAL_DATA_W-1:0] push_data;
    logic                      clear_ovf;
    logic                      full;
    logic                      empty;
    logic                      overflow;
    // fifo to transmitter
    logic [`SERIAL_DATA_W-1:0] head_data;
    logic                      pop;
    // register block to transmitter
    logic                      tx_enable;
    parity_mode_t              parity_mode;
    logic                      stop2;
    logic [`SERIAL_DIV_W-1:0]  divisor;

    serial_axi_regs u_regs (
        .axi_clk     (axi_clk),
        .axi_resetn  (axi_resetn),
        .awaddr      (awaddr),
        .awvalid     (awvalid),
        .awready     (awready),
        .wdata       (wdata),
        .wstrb       (wstrb),
        .wvalid      (wvalid),
        .wready      (wready),
        .bresp       (bresp),
        .bvalid      (bvalid),
        .bready      (bready),
        .araddr      (araddr),
        .arvalid     (arvalid),
        .arready     (arready),
        .rdata       (rdata),
        .rresp       (rresp),
        .rvalid      (rvalid),
        .rready      (rready),
        .push        (push),
        .push_data   (push_data),
        .clear_ovf   (clear_ovf),
        .tx_enable   (tx_enable),
        .parity_mode (parity_mode),
        .stop2       (stop2),
        .divisor     (divisor),
        .full        (full),
        .empty       (empty),
        .overflow    (overflow)
    );

    serial_tx_fifo u_fifo (
        .axi_clk    (axi_clk),
        .axi_resetn (axi_resetn),
        .push       (push),
        .push_data  (push_data),
        .pop        (pop),
        .clear_ovf  (clear_ovf),
        .head_data  (head_data),
        .full       (full),
        .empty      (empty),
        .overflow   (overflow)
    );

    serial_transmitter u_tx (
        .axi_clk     (axi_clk),
        .axi_resetn  (axi_resetn),
        .tx_enable   (tx_enable),
        .parity_mode (parity_mode),
        .stop2       (stop2),
        .divisor     (divisor),
        .empty       (empty),
        .head_data   (head_data),
        .pop         (pop),
        .tx_out      (tx_out)
    );

endmodule

`default_nettype wire

//--- run_sim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

LOG=sim.log

rm -rf obj_dir
verilator --binary --timing --timescale 1ns/1ns \
    -f filelist.f --top-module serial_tb -o serial_sim

./obj_dir/serial_sim | tee "$LOG"

if grep -q "\*\*\* FAILED \*\*\*" "$LOG"; then
    echo "simulation failed, see $LOG"
    exit 1
fi

echo "simulation passed"
exit 0
